/* tb.f */
+incdir+hw
hw/rf_word_pkg.sv
hw/rf_bus_pkg.sv
hw/rf_write_port.sv
hw/rf_storage.sv
hw/rf_read_port.sv
hw/rf_top.sv
bench/rf_top_sva.sv
bench/tb_rf_top.sv

/* bench/tb_rf_top.sv */
/*
  Table-driven testbench for rf_top. Writes go through the full req/ack
  handshake, and expected reads come from a local model of the register rules.
  Zero checks for addresses 16 to 31 assume the 16-register build.
*/
`timescale 1ns/1ps
`include "rf_config.svh"

module tb_rf_top;

  import rf_word_pkg::*;
  import rf_bus_pkg::*;

  typedef enum logic {OP_WR, OP_RD} op_e;

  typedef struct {
    op_e      op;
    rf_addr_t addr;
    rf_addr_t addr_b;
    rf_be_t   be;
    bit       rnd;
    int       hold;
    bit       exp_zero;
  } row_t;

  logic     clk_i;
  logic     rst_ni;
  logic     wr_req_i;
  rf_wreq_t wr_i;
  logic     wr_ack_o;
  rf_addr_t raddr_a_i;
  rf_addr_t raddr_b_i;
  rf_word_u rdata_a_o;
  rf_word_u rdata_b_o;
  logic     core_sleep_o;

  row_t                  rows_q[$];
  bit                    table_ready = 1'b0;
  logic [31:0]           lcg_state   = 32'd17560;
  logic [`RF_DATA_W-1:0] model [32];

  rf_top rf_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_req_i     (wr_req_i),
    .wr_i         (wr_i),
    .wr_ack_o     (wr_ack_o),
    .raddr_a_i    (raddr_a_i),
    .raddr_b_i    (raddr_b_i),
    .rdata_a_o    (rdata_a_o),
    .rdata_b_o    (rdata_b_o),
    .core_sleep_o (core_sleep_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // x0 and out-of-range writes never land
  task automatic model_write(input rf_addr_t addr, input rf_be_t be, input logic [31:0] data);
    if ((addr != 0) && (addr < `RF_NUM_REGS)) begin
      for (int b = 0; b < `RF_BYTES; b++) begin
        if (be[b]) begin
          model[addr][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic add_row(input op_e op, input rf_addr_t addr, input rf_addr_t addr_b,
                         input rf_be_t be, input bit rnd, input int hold, input bit exp_zero);
    row_t r;
    r.op       = op;
    r.addr     = addr;
    r.addr_b   = addr_b;
    r.be       = be;
    r.rnd      = rnd;
    r.hold     = hold;
    r.exp_zero = exp_zero;
    rows_q.push_back(r);
  endtask

  task automatic build_table();
    for (int i = 0; i < 32; i++) begin
      add_row(OP_RD, i, 31 - i, '0, 1'b0, 0, 1'b1);
    end
    for (int i = 1; i < 16; i++) begin
      add_row(OP_WR, i, 0, '1, 1'b1, 0, 1'b0);
    end
    for (int i = 1; i < 16; i++) begin
      add_row(OP_RD, i, 16 - i, '0, 1'b0, 0, 1'b0);
    end
    // Partial byte enables over existing words
    add_row(OP_WR, 3, 0, 4'b0001, 1'b1, 0, 1'b0);
    add_row(OP_WR, 5, 0, 4'b0110, 1'b0, 0, 1'b0);
    add_row(OP_WR, 7, 0, 4'b1000, 1'b1, 0, 1'b0);
    add_row(OP_WR, 9, 0, 4'b0101, 1'b1, 0, 1'b0);
    add_row(OP_WR, 15, 0, 4'b0000, 1'b1, 0, 1'b0);
    add_row(OP_RD, 3, 5, '0, 1'b0, 0, 1'b0);
    add_row(OP_RD, 7, 9, '0, 1'b0, 0, 1'b0);
    add_row(OP_RD, 15, 14, '0, 1'b0, 0, 1'b0);
    // Writes that must be dropped
    add_row(OP_WR, 0, 0, '1, 1'b1, 0, 1'b0);
    add_row(OP_WR, 16, 0, '1, 1'b1, 0, 1'b0);
    add_row(OP_WR, 23, 0, '1, 1'b1, 0, 1'b0);
    add_row(OP_WR, 31, 0, '1, 1'b1, 0, 1'b0);
    add_row(OP_RD, 0, 16, '0, 1'b0, 0, 1'b1);
    add_row(OP_RD, 23, 31, '0, 1'b0, 0, 1'b1);
    for (int i = 1; i < 16; i++) begin
      add_row(OP_RD, i, (i % 15) + 1, '0, 1'b0, 0, 1'b0);
    end
    // Req held past ack with changed data
    add_row(OP_WR, 4, 0, '1, 1'b1, 3, 1'b0);
    add_row(OP_WR, 12, 0, 4'b0011, 1'b1, 2, 1'b0);
    add_row(OP_RD, 4, 12, '0, 1'b0, 0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Row execution
  //////////////////////////////////////////////////

  task automatic run_read(input row_t r);
    @(negedge clk_i);
    raddr_a_i = r.addr;
    raddr_b_i = r.addr_b;
    #1;
    if (r.exp_zero) begin
      check_val("rdata_a_o", rdata_a_o, '0);
      check_val("rdata_b_o", rdata_b_o, '0);
    end else begin
      check_val("rdata_a_o", rdata_a_o, model[r.addr]);
      check_val("rdata_b_o", rdata_b_o, model[r.addr_b]);
    end
  endtask

  task automatic run_write(input row_t r);
    logic [31:0] data;
    data = r.rnd ? lcg_next() : {4{3'b101, r.addr}};
    @(negedge clk_i);
    wr_i.addr = r.addr;
    wr_i.be   = r.be;
    wr_i.data = data;
    wr_req_i  = 1'b1;
    raddr_a_i = r.addr;
    raddr_b_i = r.addr;
    model_write(r.addr, r.be, data);
    #1;
    check_val("core_sleep_o", core_sleep_o, 1'b0);
    // Commit cycle, the new word is forwarded before storage takes it
    check_val("rdata_a_o", rdata_a_o, model[r.addr]);
    check_val("rdata_b_o", rdata_b_o, model[r.addr]);
    do begin
      @(negedge clk_i);
      check_val("core_sleep_o", core_sleep_o, 1'b0);
    end while (!wr_ack_o);
    if (r.hold > 0) begin
      wr_i.data = ~data;
      wr_i.be   = '1;
    end
    #1;
    check_val("rdata_a_o", rdata_a_o, model[r.addr]);
    check_val("rdata_b_o", rdata_b_o, model[r.addr]);
    repeat (r.hold) begin
      @(negedge clk_i);
      check_val("wr_ack_o", wr_ack_o, 1'b1);
      check_val("core_sleep_o", core_sleep_o, 1'b0);
      #1;
      check_val("rdata_a_o", rdata_a_o, model[r.addr]);
    end
    @(negedge clk_i);
    wr_req_i = 1'b0;
    #1;
    check_val("core_sleep_o", core_sleep_o, 1'b0);
    do begin
      @(negedge clk_i);
    end while (wr_ack_o);
    check_val("rdata_a_o", rdata_a_o, model[r.addr]);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_ni    = 1'b0;
    wr_req_i  = 1'b0;
    wr_i      = '0;
    raddr_a_i = '0;
    raddr_b_i = '0;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    check_val("wr_ack_o", wr_ack_o, 1'b0);
    check_val("core_sleep_o", core_sleep_o, 1'b1);
    foreach (rows_q[i]) begin
      if (rows_q[i].op == OP_WR) begin
        run_write(rows_q[i]);
        // Idle gap between handshakes
        @(negedge clk_i);
        check_val("wr_ack_o", wr_ack_o, 1'b0);
        check_val("core_sleep_o", core_sleep_o, 1'b1);
      end else begin
        run_read(rows_q[i]);
      end
    end
    $display("All tests passed!");
    $finish;
  end

  initial begin : watchdog
    wait (table_ready);
    repeat (rows_q.size() * 8 + 20) @(posedge clk_i);
    $display("Timeout: the run did not finish within the expected number of cycles");
    $display("Test failures found");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* bench/rf_top_sva.sv */
/*
  Handshake and sleep rules for rf_top, attached by bind.
  All properties are disabled during reset.
*/
`timescale 1ns/1ps

module rf_top_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic wr_req_i,
  input logic wr_ack_o,
  input logic core_sleep_o
);

  // Ack only answers a pending request
  ack_rise_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(wr_ack_o) |-> $past(wr_req_i))
    else $error("ack rose without a request");

  ack_fall_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(wr_ack_o) |-> !$past(wr_req_i))
    else $error("ack fell while the request was still high");

  sleep_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_ack_o |-> !core_sleep_o)
    else $error("sleep high while ack is high");

  // Requester side of the four-phase protocol
  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_req_i && !wr_ack_o) |=> wr_req_i)
    else $error("request dropped before ack");

endmodule

bind rf_top rf_top_sva rf_top_sva_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .wr_req_i     (wr_req_i),
  .wr_ack_o     (wr_ack_o),
  .core_sleep_o (core_sleep_o)
);

/* hw/rf_top.sv */
/*
  Register file subsystem: handshake write port, storage, two read ports.
  Register count is fixed at build time in rf_config.svh.
*/
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Write handshake
  input  logic                  wr_req_i,
  input  rf_bus_pkg::rf_wreq_t  wr_i,
  output logic                  wr_ack_o,

  // Read ports
  input  rf_word_pkg::rf_addr_t raddr_a_i,
  input  rf_word_pkg::rf_addr_t raddr_b_i,
  output rf_word_pkg::rf_word_u rdata_a_o,
  output rf_word_pkg::rf_word_u rdata_b_o,

  output logic                  core_sleep_o
);

  import rf_word_pkg::*;
  import rf_bus_pkg::*;

  rf_commit_t commit;
  rf_array_t  regs;

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  rf_write_port u_write_port (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_req_i     (wr_req_i),
    .wr_i         (wr_i),
    .wr_ack_o     (wr_ack_o),
    .commit_o     (commit),
    .core_sleep_o (core_sleep_o)
  );

  rf_storage u_storage (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .commit_i (commit),
    .regs_o   (regs)
  );

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  rf_read_port u_read_port (
    .raddr_a_i (raddr_a_i),
    .raddr_b_i (raddr_b_i),
    .commit_i  (commit),
    .regs_i    (regs),
    .rdata_a_o (rdata_a_o),
    .rdata_b_o (rdata_b_o)
  );

endmodule

/* hw/rf_read_port.sv */
/*
  Two combinational read ports. x0 and addresses at or above RF_NUM_REGS
  read zero. A commit in flight to the read address is forwarded merged.
*/
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_read_port (
  input  rf_word_pkg::rf_addr_t  raddr_a_i,
  input  rf_word_pkg::rf_addr_t  raddr_b_i,

  input  rf_bus_pkg::rf_commit_t commit_i,
  input  rf_word_pkg::rf_array_t regs_i,

  output rf_word_pkg::rf_word_u  rdata_a_o,
  output rf_word_pkg::rf_word_u  rdata_b_o
);

  import rf_word_pkg::*;
  import rf_bus_pkg::*;

  localparam int IDX_W = $clog2(`RF_NUM_REGS);

  // One read lookup, shared by both ports
  function automatic rf_word_u read_word(rf_addr_t raddr, rf_array_t regs,
                                         rf_commit_t commit);
    rf_word_u w;
    logic     in_range;
    w        = '0;
    in_range = (raddr != '0) && (raddr < `RF_NUM_REGS);
    if (in_range) begin
      w = regs[raddr[IDX_W-1:0]];
      // Write landing this cycle wins over the stored word
      if (commit.valid && (commit.addr == raddr)) begin
        w = rf_merge(w, commit.data, commit.be);
      end
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Ports
  //////////////////////////////////////////////////

  always_comb begin
    rdata_a_o = read_word(raddr_a_i, regs_i, commit_i);
  end

  always_comb begin
    rdata_b_o = read_word(raddr_b_i, regs_i, commit_i);
  end

endmodule

/* hw/rf_storage.sv */
/*
  Flip-flop register array, all words reset to zero.
  Commits to x0 or to addresses at or above RF_NUM_REGS are dropped,
  so word 0 stays zero.
*/
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_storage (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  rf_bus_pkg::rf_commit_t commit_i,

  output rf_word_pkg::rf_array_t regs_o
);

  import rf_word_pkg::*;

  localparam int IDX_W = $clog2(`RF_NUM_REGS);

  rf_array_t        regs_q;
  logic             addr_ok;
  logic             wr_en;
  logic [IDX_W-1:0] wr_idx;
  rf_word_u         wr_word;

  //////////////////////////////////////////////////
  // Write qualification
  //////////////////////////////////////////////////

  // Stands in for the clock gate of a full core
  assign addr_ok = (commit_i.addr != '0) && (commit_i.addr < `RF_NUM_REGS);
  assign wr_en   = commit_i.valid & addr_ok;
  assign wr_idx  = commit_i.addr[IDX_W-1:0];

  // Byte merge against the current contents
  assign wr_word = rf_merge(regs_q[wr_idx], commit_i.data, commit_i.be);

  //////////////////////////////////////////////////
  // Register array
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (wr_en) begin
      regs_q[wr_idx] <= wr_word;
    end
  end

  assign regs_o = regs_q;

endmodule

/* hw/rf_write_port.sv */
/*
  Four-phase req/ack slave. One commit per request, issued in the cycle
  before ack rises. wr_i must be stable while req is high.
  Sleep is high only when neither req nor ack is high.
*/
`timescale 1ns/1ps
`include "rf_config.svh"

module rf_write_port (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   wr_req_i,
  input  rf_bus_pkg::rf_wreq_t   wr_i,
  output logic                   wr_ack_o,

  output rf_bus_pkg::rf_commit_t commit_o,

  output logic                   core_sleep_o
);

  logic ack_q;
  logic req_new;
  logic busy;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Req seen while ack still low starts a new transfer
  assign req_new = wr_req_i & ~ack_q;

  // Ack set by a new request, held until req drops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (req_new) begin
      ack_q <= 1'b1;
    end else if (!wr_req_i) begin
      ack_q <= 1'b0;
    end
  end

  assign wr_ack_o = ack_q;

  //////////////////////////////////////////////////
  // Commit
  //////////////////////////////////////////////////

  // Storage takes the write on the same edge that raises ack
  assign commit_o.valid = req_new;
  assign commit_o.addr  = wr_i.addr;
  assign commit_o.be    = wr_i.be;
  assign commit_o.data  = wr_i.data;

  //////////////////////////////////////////////////
  // Sleep
  //////////////////////////////////////////////////

  // Busy from the first req cycle until ack has dropped again
  assign busy         = wr_req_i | ack_q;
  assign core_sleep_o = ~busy;

endmodule

/* hw/rf_bus_pkg.sv */
/*
  Write request and commit structs passed between the register file blocks.
  Commit valid lasts one cycle per accepted request.
*/
`include "rf_config.svh"

package rf_bus_pkg;

  import rf_word_pkg::*;

  //////////////////////////////////////////////////
  // External write request
  //////////////////////////////////////////////////

  // Held stable by the requester while req is high
  typedef struct packed {
    rf_addr_t addr;
    rf_be_t   be;
    rf_word_u data;
  } rf_wreq_t;

  //////////////////////////////////////////////////
  // Internal write commit
  //////////////////////////////////////////////////

  // Single-cycle write into storage, also seen by the read port
  typedef struct packed {
    logic     valid;
    rf_addr_t addr;
    rf_be_t   be;
    rf_word_u data;
  } rf_commit_t;

endpackage

/* hw/rf_word_pkg.sv */
/*
  Register word and address types. A word is seen whole for reads and as
  bytes for byte-enable merges. Needs rf_config.svh on the include path.
*/
`include "rf_config.svh"

package rf_word_pkg;

  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

  typedef logic [`RF_BYTES-1:0] rf_be_t;

  // Same 32 bits, two views
  typedef union packed {
    logic [`RF_DATA_W-1:0]     word;
    logic [`RF_BYTES-1:0][7:0] bytes;
  } rf_word_u;

  // Whole register state, word 0 at the bottom
  typedef rf_word_u [`RF_NUM_REGS-1:0] rf_array_t;

  // Old word with the enabled bytes of the new word put in
  function automatic rf_word_u rf_merge(rf_word_u old_w, rf_word_u new_w, rf_be_t be);
    rf_word_u res;
    res = old_w;
    for (int b = 0; b < `RF_BYTES; b++) begin
      if (be[b]) begin
        res.bytes[b] = new_w.bytes[b];
      end
    end
    return res;
  endfunction

endpackage

/* hw/rf_config.svh */
/*
  Build-wide register file sizes. RF_NUM_REGS is 16 (embedded) or 32.
  RF_ADDR_W stays 5 whatever the register count.
*/
`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

//////////////////////////////////////////////////
// Register word
//////////////////////////////////////////////////

// Width of one architectural register
`define RF_DATA_W 32

// Byte lanes per register, used for byte enables
`define RF_BYTES (`RF_DATA_W / 8)

//////////////////////////////////////////////////
// Register count and addressing
//////////////////////////////////////////////////

// 16 for the embedded variant, 32 for the full set
`define RF_NUM_REGS 16

// Set by the instruction encoding
`define RF_ADDR_W 5

`endif
